// ==== design/sens_io_params.svh ====
// ==========================================================
// widths, register map and control bit positions for the
// sensor receiver, included by the package and the RTL
// ==========================================================
`ifndef SENS_IO_PARAMS_SVH
`define SENS_IO_PARAMS_SVH

// pixel bus and line length
`define SENS_PXD_WIDTH        12  // sensor data pins
`define SENS_LINE_WIDTH_BITS  16  // width register and hact counter

// wishbone word address space
`define SENS_WB_ADR_BITS      3
`define SENS_REG_CTRL         3'd0  // set/clear pairs
`define SENS_REG_STATUS       3'd1  // alive flags, write clears
`define SENS_REG_WIDTH        3'd3  // 0 selects pad hact

// value bit of each ctrl pair, enable sits one bit up
`define SENS_CTRL_MRST        0
`define SENS_CTRL_ARST        2
`define SENS_CTRL_ARO         4

`define SENS_ALIVE_EXT_BITS   4  // external toggle inputs

`endif

// ==== design/sens_io_pkg.sv ====
// ==========================================================
// packed types passed between the register block, the pixel
// path and the testbench
// ==========================================================
`include "sens_io_params.svh"

package sens_io_pkg;

    // one pixel bus sample
    typedef struct packed {
        logic                        vact;
        logic                        hact;
        logic [`SENS_PXD_WIDTH-1:0]  pxd;
    } sens_pix_t;

    // configuration from the register block to the pixel path
    typedef struct packed {
        logic                              line_rst;      // sensor held in reset
        logic                              use_pad_hact;  // width register is 0
        logic [`SENS_LINE_WIDTH_BITS-1:0]  line_width_m1;
    } sens_ctrl_t;

    // sticky activity flags, status register layout
    typedef struct packed {
        logic [`SENS_ALIVE_EXT_BITS-1:0]  ext;
        logic                             vact_alive;
        logic                             hact_pad_alive;
        logic                             hact_alive;
    } sens_alive_t;

    // wishbone classic master side
    typedef struct packed {
        logic                          cyc;
        logic                          stb;
        logic                          we;
        logic [`SENS_WB_ADR_BITS-1:0]  adr;
        logic [31:0]                   dat;
    } wb_req_t;

    // wishbone classic slave side
    typedef struct packed {
        logic         ack;
        logic [31:0]  dat;
    } wb_rsp_t;

endpackage

// ==== design/sens_io_regs.sv ====
// ==========================================================
// wishbone classic slave with sensor control, line width and
// status registers; feeds config to the pixel path
// ==========================================================
`include "sens_io_params.svh"

module sens_io_regs (
    input  logic                      mclk,
    input  logic                      async_prst_with_sens_mrst,
    input  logic                      trigger_mode_i,  // triggered mode
    input  logic                      trig_i,          // per-sensor trigger
    input  sens_io_pkg::wb_req_t      wb_req_i,
    input  sens_io_pkg::sens_alive_t  alive_i,
    output sens_io_pkg::wb_rsp_t      wb_rsp_o,
    output sens_io_pkg::sens_ctrl_t   ctrl_o,
    output logic                      status_clr_o,    // one cycle on status write
    output logic                      mrst_o,
    output logic                      arst_o,
    output logic                      aro_o
);
    import sens_io_pkg::*;

    wb_rsp_t                          rsp_q;
    sens_ctrl_t                       ctrl;
    logic                             wb_acc;     // first cycle of a request
    logic                             wb_wr;
    logic                             set_ctrl;
    logic                             set_width;
    logic [31:0]                      rd_mux;
    logic                             mrst_r;
    logic                             arst_r;
    logic                             aro_soft;
    logic [`SENS_LINE_WIDTH_BITS-1:0] width_r;    // as written, 0 = pad hact

    // ack goes high the clock after the request, never two in a row
    assign wb_acc    = wb_req_i.cyc & wb_req_i.stb & ~rsp_q.ack;
    assign wb_wr     = wb_acc & wb_req_i.we;
    assign set_ctrl  = wb_wr && (wb_req_i.adr == `SENS_REG_CTRL);
    assign set_width = wb_wr && (wb_req_i.adr == `SENS_REG_WIDTH);

    // flags clear on the same edge that raises ack
    assign status_clr_o = wb_wr && (wb_req_i.adr == `SENS_REG_STATUS);

    always_comb begin
        rd_mux = '0;
        case (wb_req_i.adr)
            `SENS_REG_CTRL: begin
                rd_mux[`SENS_CTRL_MRST] = mrst_r;
                rd_mux[`SENS_CTRL_ARST] = arst_r;
                rd_mux[`SENS_CTRL_ARO]  = aro_soft;
            end
            `SENS_REG_STATUS: rd_mux = 32'(alive_i);
            `SENS_REG_WIDTH:  rd_mux[`SENS_LINE_WIDTH_BITS-1:0] = width_r;
            default:          rd_mux = '0; // unmapped reads as zero
        endcase
    end

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            rsp_q    <= '0;
            mrst_r   <= 1'b0; // sensor starts in reset
            arst_r   <= 1'b0;
            aro_soft <= 1'b0;
            width_r  <= '0;
        end else begin
            rsp_q.ack <= wb_acc;
            if (wb_acc && !wb_req_i.we)
                rsp_q.dat <= rd_mux; // held while ack is high

            // enable bit one above each value bit
            if (set_ctrl && wb_req_i.dat[`SENS_CTRL_MRST + 1])
                mrst_r <= wb_req_i.dat[`SENS_CTRL_MRST];
            if (set_ctrl && wb_req_i.dat[`SENS_CTRL_ARST + 1])
                arst_r <= wb_req_i.dat[`SENS_CTRL_ARST];
            if (set_ctrl && wb_req_i.dat[`SENS_CTRL_ARO + 1])
                aro_soft <= wb_req_i.dat[`SENS_CTRL_ARO];

            if (set_width)
                width_r <= wb_req_i.dat[`SENS_LINE_WIDTH_BITS-1:0];
        end
    end

    always_comb begin
        ctrl.line_rst      = ~mrst_r;           // hold pixel path while mrst is low
        ctrl.use_pad_hact  = (width_r == '0);
        ctrl.line_width_m1 = width_r - `SENS_LINE_WIDTH_BITS'(1); // unused when 0
    end

    assign ctrl_o   = ctrl;
    assign wb_rsp_o = rsp_q;
    assign mrst_o   = mrst_r;
    assign arst_o   = arst_r;
    assign aro_o    = trigger_mode_i ? ~trig_i : aro_soft; // trigger overrides soft aro

endmodule

// ==== design/sens_pixel_capture.sv ====
// ==========================================================
// registers the sensor pins once and flags rising HACT and
// VACT; held at zero while the sensor is in reset
// ==========================================================
`include "sens_io_params.svh"

module sens_pixel_capture (
    input  logic                        mclk,
    input  logic                        async_prst_with_sens_mrst,
    input  logic                        line_rst_i,    // sensor mrst active
    input  logic [`SENS_PXD_WIDTH-1:0]  pxd_i,
    input  logic                        vact_i,
    input  logic                        hact_i,
    output sens_io_pkg::sens_pix_t      pix_o,
    output logic                        hact_pad_rise_o,
    output logic                        vact_rise_o
);
    import sens_io_pkg::*;

    sens_pix_t pix_q;
    logic      hact_prev;   // pix_q.hact one clock back
    logic      vact_prev;

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            pix_q     <= '0;
            hact_prev <= 1'b0;
            vact_prev <= 1'b0;
        end else if (line_rst_i) begin
            pix_q     <= '0; // sync hold
            hact_prev <= 1'b0;
            vact_prev <= 1'b0;
        end else begin
            pix_q     <= '{vact: vact_i, hact: hact_i, pxd: pxd_i};
            hact_prev <= pix_q.hact;
            vact_prev <= pix_q.vact;
        end
    end

    // high in the first cycle the registered level reads 1
    assign hact_pad_rise_o = pix_q.hact & ~hact_prev;
    assign vact_rise_o     = pix_q.vact & ~vact_prev;
    assign pix_o           = pix_q;

endmodule

// ==== design/sens_hact_regen.sv ====
// ==========================================================
// second pixel stage: rebuilds HACT from the line width or
// passes the pad HACT, with pxd and vact kept aligned
// ==========================================================
`include "sens_io_params.svh"

module sens_hact_regen (
    input  logic                     mclk,
    input  logic                     async_prst_with_sens_mrst,
    input  sens_io_pkg::sens_ctrl_t  ctrl_i,
    input  sens_io_pkg::sens_pix_t   pix_i,           // from capture
    input  logic                     hact_pad_rise_i,
    output sens_io_pkg::sens_pix_t   pix_o,
    output logic                     hact_rise_o      // first cycle of output hact
);
    import sens_io_pkg::*;

    sens_pix_t                        pix_q;
    logic [`SENS_LINE_WIDTH_BITS-1:0] hact_cntr;  // cycles left after this one
    logic                             hact_d;
    logic                             hact_end;

    // pad mode follows the pad level, width mode runs the counter out
    assign hact_end = ctrl_i.use_pad_hact ? ~pix_i.hact : (hact_cntr == '0);

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            pix_q     <= '0;
            hact_cntr <= '0;
            hact_d    <= 1'b0;
        end else if (ctrl_i.line_rst) begin
            pix_q     <= '0;
            hact_cntr <= '0;
            hact_d    <= 1'b0;
        end else begin
            pix_q.pxd  <= pix_i.pxd;  // same delay as hact
            pix_q.vact <= pix_i.vact;

            if (hact_pad_rise_i)
                pix_q.hact <= 1'b1;   // new line, restarts too
            else if (hact_end)
                pix_q.hact <= 1'b0;

            if (hact_pad_rise_i)
                hact_cntr <= ctrl_i.line_width_m1;
            else if (pix_q.hact && !ctrl_i.use_pad_hact)
                hact_cntr <= hact_cntr - `SENS_LINE_WIDTH_BITS'(1);

            hact_d <= pix_q.hact;
        end
    end

    assign hact_rise_o = pix_q.hact & ~hact_d;
    assign pix_o       = pix_q;

endmodule

// ==== design/sens_alive_monitor.sv ====
// ==========================================================
// sticky activity flags for status readback, cleared by a
// write to the status register
// ==========================================================
`include "sens_io_params.svh"

module sens_alive_monitor (
    input  logic                             mclk,
    input  logic                             async_prst_with_sens_mrst,
    input  logic                             status_clr_i,
    input  logic                             vact_rise_i,
    input  logic                             hact_pad_rise_i,
    input  logic                             hact_rise_i,   // regenerated hact
    input  logic [`SENS_ALIVE_EXT_BITS-1:0]  alive_ext_i,   // single-cycle pulses
    output sens_io_pkg::sens_alive_t         alive_o
);
    import sens_io_pkg::*;

    sens_alive_t alive_q;

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            alive_q <= '0;
        end else if (status_clr_i) begin
            alive_q <= '0; // clear wins over a same-cycle event
        end else begin
            if (vact_rise_i)
                alive_q.vact_alive <= 1'b1;
            if (hact_pad_rise_i)
                alive_q.hact_pad_alive <= 1'b1;
            if (hact_rise_i)
                alive_q.hact_alive <= 1'b1;
            alive_q.ext <= alive_q.ext | alive_ext_i; // accumulate pulses
        end
    end

    assign alive_o = alive_q;

endmodule

// ==== design/sens_io_top.sv ====
// ==========================================================
// sensor receiver top: register block, two-stage pixel path
// and activity monitor, all on mclk
// ==========================================================
`include "sens_io_params.svh"

module sens_io_top (
    input  logic                             mclk,
    input  logic                             async_prst_with_sens_mrst,
    input  sens_io_pkg::wb_req_t             wb_req_i,
    input  logic                             trigger_mode_i,
    input  logic                             trig_i,
    input  logic [`SENS_PXD_WIDTH-1:0]       pxd_i,
    input  logic                             vact_i,
    input  logic                             hact_i,
    input  logic [`SENS_ALIVE_EXT_BITS-1:0]  alive_ext_i,
    output sens_io_pkg::wb_rsp_t             wb_rsp_o,
    output logic                             mrst_o,
    output logic                             arst_o,
    output logic                             aro_o,
    output logic [`SENS_PXD_WIDTH-1:0]       pxd_o,   // pins + 2 clocks
    output logic                             vact_o,
    output logic                             hact_o
);
    import sens_io_pkg::*;

    sens_ctrl_t  ctrl;
    sens_alive_t alive;
    sens_pix_t   cap_pix;        // after first register
    sens_pix_t   out_pix;        // after regen stage
    logic        status_clr;
    logic        hact_pad_rise;
    logic        vact_rise;
    logic        hact_rise;

    sens_io_regs sens_io_regs_i (
        .mclk                      (mclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .trigger_mode_i            (trigger_mode_i),
        .trig_i                    (trig_i),
        .wb_req_i                  (wb_req_i),
        .alive_i                   (alive),
        .wb_rsp_o                  (wb_rsp_o),
        .ctrl_o                    (ctrl),
        .status_clr_o              (status_clr),
        .mrst_o                    (mrst_o),
        .arst_o                    (arst_o),
        .aro_o                     (aro_o)
    );

    sens_pixel_capture sens_pixel_capture_i (
        .mclk                      (mclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .line_rst_i                (ctrl.line_rst),
        .pxd_i                     (pxd_i),
        .vact_i                    (vact_i),
        .hact_i                    (hact_i),
        .pix_o                     (cap_pix),
        .hact_pad_rise_o           (hact_pad_rise),
        .vact_rise_o               (vact_rise)
    );

    sens_hact_regen sens_hact_regen_i (
        .mclk                      (mclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .ctrl_i                    (ctrl),
        .pix_i                     (cap_pix),
        .hact_pad_rise_i           (hact_pad_rise),
        .pix_o                     (out_pix),
        .hact_rise_o               (hact_rise)
    );

    sens_alive_monitor sens_alive_monitor_i (
        .mclk                      (mclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .status_clr_i              (status_clr),
        .vact_rise_i               (vact_rise),
        .hact_pad_rise_i           (hact_pad_rise),
        .hact_rise_i               (hact_rise),
        .alive_ext_i               (alive_ext_i),
        .alive_o                   (alive)
    );

    assign pxd_o  = out_pix.pxd;
    assign vact_o = out_pix.vact;
    assign hact_o = out_pix.hact; // regenerated or pad hact

endmodule

// ==== sim/sens_io_clkgen.sv ====
// ==========================================================
// testbench clock and power-on reset for the sensor receiver
// ==========================================================
module sens_io_clkgen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 10
) (
    output logic mclk,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        mclk = 1'b0;
        forever #(PERIOD_NS / 2) mclk = ~mclk; // free running
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge mclk);
        @(negedge mclk);
        rst_o = 1'b0; // released away from the active edge
    end

endmodule

// ==== sim/sens_io_tb.sv ====
// ==========================================================
// testbench for sens_io_top: wishbone register tests, pixel
// path in pad and width mode, alive flags; run from sens_io.f
// ==========================================================
`include "sens_io_params.svh"

module sens_io_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import sens_io_pkg::*;

    localparam int MODE_NONE  = 0;
    localparam int MODE_ZERO  = 1;
    localparam int MODE_PAD   = 2;
    localparam int MODE_WIDTH = 3;
    localparam int TEST_CYCLES = 10 + 32 + 200 + 40 + 220 + 4 * 190 + 100; // rough sum
    localparam int WATCHDOG_NS = TEST_CYCLES * 8 * 2;                      // 2x margin

    logic                            mclk, rst;
    wb_req_t                         wb_req;
    wb_rsp_t                         wb_rsp;
    logic                            trigger_mode, trig;
    logic [`SENS_PXD_WIDTH-1:0]      pxd_drv, pxd_o;
    logic                            vact_drv, hact_drv, vact_o, hact_o;
    logic [`SENS_ALIVE_EXT_BITS-1:0] alive_ext;
    logic                            mrst_o, arst_o, aro_o;
    logic [31:0]                     lfsr_q = 32'h22a8;
    logic                            mrst_m, arst_m, aro_m; // register model
    int                              mode = MODE_NONE;
    bit                              aro_chk = 1'b0;
    int                              width_w, rem;          // hact model
    sens_pix_t                       h0, h1, h2, pins_now;  // pins at edges k-2..k

    sens_io_clkgen #(.PERIOD_NS(8), .RST_CYCLES(10)) sens_io_clkgen_i (.mclk(mclk), .rst_o(rst));

    sens_io_top sens_io_top_i (
        .mclk(mclk), .async_prst_with_sens_mrst(rst), .wb_req_i(wb_req),
        .trigger_mode_i(trigger_mode), .trig_i(trig), .pxd_i(pxd_drv), .vact_i(vact_drv),
        .hact_i(hact_drv), .alive_ext_i(alive_ext), .wb_rsp_o(wb_rsp), .mrst_o(mrst_o),
        .arst_o(arst_o), .aro_o(aro_o), .pxd_o(pxd_o), .vact_o(vact_o), .hact_o(hact_o)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("mismatch %s expected %0h actual %0h", name, exp, act);
            report_failure("check failed");
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_step()}; // one step per bit
        return r;
    endfunction

    task automatic wb_xfer(input logic we, input logic [`SENS_WB_ADR_BITS-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(negedge mclk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(negedge mclk);
            waited++;
            if (waited > 16)
                report_failure("wishbone ack never came");
        end while (!wb_rsp.ack);
        rdat   = wb_rsp.dat; // valid while ack high
        wb_req = '0;         // stb low before next transfer
    endtask

    task automatic quiet(input int n);
        @(negedge mclk);
        {pxd_drv, vact_drv, hact_drv, alive_ext} = '0;
        repeat (n) @(negedge mclk);
    endtask

    task automatic drive_pixels(input int n, input bit pulsed);
        logic [31:0] r;
        int          run;
        run = 0;
        repeat (n) begin
            @(negedge mclk);
            r        = take(`SENS_PXD_WIDTH);
            pxd_drv  = r[`SENS_PXD_WIDTH-1:0];
            r        = take(1);
            vact_drv = r[0];
            if (pulsed) begin // pad lines of 1..8 cycles, any width
                if (run == 0) begin
                    r        = take(3);
                    run      = int'(r[2:0]) + 1;
                    hact_drv = ~hact_drv;
                end
                run--;
            end else begin
                r        = take(1);
                hact_drv = r[0];
            end
        end
    endtask

    task automatic write_ctrl(input logic [5:0] d);
        logic [31:0] rd, exp;
        wb_xfer(1'b1, `SENS_REG_CTRL, {26'd0, d}, rd);
        if (d[`SENS_CTRL_MRST + 1]) mrst_m = d[`SENS_CTRL_MRST];
        if (d[`SENS_CTRL_ARST + 1]) arst_m = d[`SENS_CTRL_ARST];
        if (d[`SENS_CTRL_ARO + 1])  aro_m  = d[`SENS_CTRL_ARO];
        exp = '0;
        exp[`SENS_CTRL_MRST] = mrst_m;
        exp[`SENS_CTRL_ARST] = arst_m;
        exp[`SENS_CTRL_ARO]  = aro_m;
        wb_xfer(1'b0, `SENS_REG_CTRL, '0, rd);
        check_eq("ctrl readback", exp, rd);
        check_eq("ctrl pins", {29'd0, aro_m, arst_m, mrst_m}, {29'd0, aro_o, arst_o, mrst_o});
    endtask

    // pins sampled at the edge, outputs checked 2 ns later when settled
    always @(posedge mclk) begin
        pins_now = '{vact: vact_drv, hact: hact_drv, pxd: pxd_drv};
        #2;
        h0 = h1;
        h1 = h2;
        h2 = pins_now;
        if (mode != MODE_WIDTH) rem = 0;
        else if (h1.hact && !h0.hact) rem = width_w; // restart on pad rise
        else if (rem != 0) rem--;
        case (mode)
            MODE_ZERO:  check_eq("line hold", '0, 32'({vact_o, hact_o, pxd_o}));
            MODE_PAD:   check_eq("pad mode", 32'(h1), 32'({vact_o, hact_o, pxd_o}));
            MODE_WIDTH: check_eq("width mode", 32'({h1.vact, rem != 0, h1.pxd}),
                                 32'({vact_o, hact_o, pxd_o}));
            default: ;
        endcase
        if (aro_chk)
            check_eq("aro select", 32'(trigger_mode ? !trig : aro_m), 32'(aro_o));
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] rd, r;
        sens_alive_t exp_alive;
        wb_req = '0;
        {trigger_mode, trig, pxd_drv, vact_drv, hact_drv, alive_ext} = '0;
        {mrst_m, arst_m, aro_m} = '0;
        h0 = '0;
        h1 = '0;
        h2 = '0;
        wait (rst === 1'b0);
        @(negedge mclk);
        check_eq("reset outputs", '0, 32'({wb_rsp.ack, mrst_o, arst_o, aro_o,
                                           vact_o, hact_o, pxd_o}));
        wb_xfer(1'b0, `SENS_REG_CTRL, '0, rd);
        check_eq("reset ctrl read", '0, rd);
        mode = MODE_ZERO;                       // sensor still in mrst
        drive_pixels(32, 1'b0);
        mode = MODE_NONE;
        repeat (20) begin
            r = take(6);
            write_ctrl(r[5:0]);
        end
        write_ctrl(6'b000011);                  // release mrst
        aro_chk = 1'b1;
        for (int m = 0; m < 2; m++) begin
            trigger_mode = m[0];
            repeat (16) begin
                @(negedge mclk);
                r    = take(1);
                trig = r[0];
            end
        end
        aro_chk = 1'b0;
        wb_xfer(1'b1, `SENS_REG_WIDTH, '0, rd);
        quiet(4);
        mode = MODE_PAD;
        drive_pixels(200, 1'b0);
        mode = MODE_NONE;
        repeat (4) begin
            quiet(8);
            r       = take(6);
            width_w = int'(r[5:0]) % 40 + 1;    // 1..40
            wb_xfer(1'b1, `SENS_REG_WIDTH, 32'(width_w), rd);
            wb_xfer(1'b0, `SENS_REG_WIDTH, '0, rd);
            check_eq("width readback", 32'(width_w), rd);
            quiet(4);
            mode = MODE_WIDTH;
            drive_pixels(120, 1'b1);
            quiet(48);                          // let the last line run out
            mode = MODE_NONE;
        end
        wb_xfer(1'b1, `SENS_REG_STATUS, '0, rd);
        wb_xfer(1'b0, `SENS_REG_STATUS, '0, rd);
        check_eq("status after clear", '0, rd);
        r = take(`SENS_ALIVE_EXT_BITS);
        @(negedge mclk);
        {vact_drv, hact_drv} = 2'b11;
        alive_ext = r[`SENS_ALIVE_EXT_BITS-1:0];
        @(negedge mclk);
        alive_ext = '0;                         // one-cycle pulse
        repeat (4) @(negedge mclk);
        quiet(48);
        exp_alive = '{ext: r[`SENS_ALIVE_EXT_BITS-1:0], vact_alive: 1'b1,
                      hact_pad_alive: 1'b1, hact_alive: 1'b1};
        wb_xfer(1'b0, `SENS_REG_STATUS, '0, rd);
        check_eq("status flags", 32'(exp_alive), rd);
        wb_xfer(1'b1, `SENS_REG_STATUS, '0, rd);
        quiet(4);
        wb_xfer(1'b0, `SENS_REG_STATUS, '0, rd);
        check_eq("status cleared", '0, rd);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== sens_io.f ====
+incdir+design
design/sens_io_pkg.sv
design/sens_io_regs.sv
design/sens_pixel_capture.sv
design/sens_hact_regen.sv
design/sens_alive_monitor.sv
design/sens_io_top.sv
sim/sens_io_clkgen.sv
sim/sens_io_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the sensor receiver testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module sens_io_tb \
    -f sens_io.f -o Vsens_io_tb &&
./obj_dir/Vsens_io_tb || exit 1
